//--- hdl/bridge_pkg.sv
// AXI to APB bridge definitions

package bridge_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 64;
  localparam int APB_DATA_W = 32;
  localparam int ID_W       = 4;

  // APB address map, eight slaves of one 4 KB window each
  localparam int APB_ADDR_W     = 12;
  localparam int APB_NUM_SLAVES = 8;
  localparam int SLAVE_SEL_W    = 3;   // Address bits above the window

  // Request queues
  localparam int REQ_FIFO_DEPTH = 4;
  localparam int REQ_PTR_W      = $clog2(REQ_FIFO_DEPTH);
  localparam int REQ_CNT_W      = $clog2(REQ_FIFO_DEPTH + 1);

  // AXI size code of a full 64-bit beat
  localparam logic [2:0] SIZE_64 = 3'd3;

  // ----------------------------------------------------------------------
  // Basic types
  // ----------------------------------------------------------------------
  typedef logic [AXI_ADDR_W-1:0]     addr_t;
  typedef logic [AXI_DATA_W-1:0]     axi_data_t;
  typedef logic [APB_DATA_W-1:0]     apb_data_t;
  typedef logic [APB_ADDR_W-1:0]     apb_addr_t;
  typedef logic [ID_W-1:0]           id_t;
  typedef logic [1:0]                resp_t;
  typedef logic [APB_NUM_SLAVES-1:0] sel_t;   // One-hot PSEL

  // Only OKAY is ever returned
  localparam resp_t RESP_OKAY = 2'b00;

  // ----------------------------------------------------------------------
  // Queued requests
  // ----------------------------------------------------------------------

  // Write request, address and data taken in the same handshake
  typedef struct packed {
    id_t       id;
    addr_t     addr;
    logic      is64;   // Size 3, two APB beats
    axi_data_t data;
  } wr_req_t;

  // Read request
  typedef struct packed {
    id_t   id;
    addr_t addr;
    logic  is64;
  } rd_req_t;

endpackage

//--- hdl/axi_req_capture.sv
// AXI request capture

`timescale 1ns/1ns

module axi_req_capture
(
  input  logic                 ACLK,
  input  logic                 ARESETn,

  // Write address and data, accepted together
  input  logic                 AWVALID_i,
  input  bridge_pkg::id_t      AWID_i,
  input  bridge_pkg::addr_t    AWADDR_i,
  input  logic [2:0]           AWSIZE_i,
  output logic                 AWREADY_o,
  input  logic                 WVALID_i,
  input  bridge_pkg::axi_data_t WDATA_i,
  output logic                 WREADY_o,

  // Read address
  input  logic                 ARVALID_i,
  input  bridge_pkg::id_t      ARID_i,
  input  bridge_pkg::addr_t    ARADDR_i,
  input  logic [2:0]           ARSIZE_i,
  output logic                 ARREADY_o,

  // Queue side
  input  logic                 wr_full_i,
  input  logic                 rd_full_i,
  output logic                 wr_push_o,
  output logic                 rd_push_o,
  output bridge_pkg::wr_req_t  wr_req_o,
  output bridge_pkg::rd_req_t  rd_req_o
);

  import bridge_pkg::*;

  logic wr_hs;
  logic rd_hs;

  // A request sits one cycle in the output register before the queue
  // sees it, so no second request is taken while a push is pending
  assign wr_hs = AWVALID_i & WVALID_i & ~wr_full_i & ~wr_push_o;
  assign rd_hs = ARVALID_i & ~rd_full_i & ~rd_push_o;

  assign AWREADY_o = wr_hs;   // Joint AW/W handshake
  assign WREADY_o  = wr_hs;
  assign ARREADY_o = rd_hs;

  // ----------------------------------------------------------------------
  // Push pulses
  // ----------------------------------------------------------------------
  always_ff @(posedge ACLK, negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      wr_push_o <= 1'b0;
      rd_push_o <= 1'b0;
    end
    else
    begin
      wr_push_o <= wr_hs;
      rd_push_o <= rd_hs;
    end
  end

  // Request payloads, loaded in the handshake cycle
  always_ff @(posedge ACLK)
  begin
    if (wr_hs)
    begin
      wr_req_o.id   <= AWID_i;
      wr_req_o.addr <= AWADDR_i;
      wr_req_o.is64 <= (AWSIZE_i == SIZE_64);
      wr_req_o.data <= WDATA_i;
    end
    if (rd_hs)
    begin
      rd_req_o.id   <= ARID_i;
      rd_req_o.addr <= ARADDR_i;
      rd_req_o.is64 <= (ARSIZE_i == SIZE_64);
    end
  end

endmodule

//--- hdl/req_fifo.sv
// Request queue

`timescale 1ns/1ns

module req_fifo
#(
  parameter type payload_t = logic [7:0]
)
(
  input  logic     ACLK,
  input  logic     ARESETn,

  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,

  input  logic     pop_i,
  output payload_t data_o,       // Head entry, valid with not_empty_o
  output logic     not_empty_o
);

  import bridge_pkg::*;

  payload_t               mem [REQ_FIFO_DEPTH];
  logic [REQ_PTR_W-1:0]   wr_ptr;
  logic [REQ_PTR_W-1:0]   rd_ptr;
  logic [REQ_CNT_W-1:0]   count;
  logic                   do_push;
  logic                   do_pop;

  assign full_o      = (count == REQ_CNT_W'(REQ_FIFO_DEPTH));
  assign not_empty_o = (count != '0);
  assign data_o      = mem[rd_ptr];   // Fall-through head

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & not_empty_o;

  // ----------------------------------------------------------------------
  // Pointers and fill level
  // ----------------------------------------------------------------------
  always_ff @(posedge ACLK, negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == REQ_PTR_W'(REQ_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == REQ_PTR_W'(REQ_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push != do_pop)
        count <= do_push ? count + 1'b1 : count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge ACLK)
  begin
    if (do_push)
      mem[wr_ptr] <= data_i;
  end

endmodule

//--- hdl/apb_sequencer.sv
// APB transfer sequencer

`timescale 1ns/1ns

module apb_sequencer
(
  input  logic                  ACLK,
  input  logic                  ARESETn,

  // Queue heads
  input  bridge_pkg::wr_req_t   wr_req_i,
  input  logic                  wr_pending_i,
  output logic                  wr_pop_o,
  input  bridge_pkg::rd_req_t   rd_req_i,
  input  logic                  rd_pending_i,
  output logic                  rd_pop_o,

  // APB master
  output logic                  PENABLE_o,
  output logic                  PWRITE_o,
  output bridge_pkg::apb_addr_t PADDR_o,
  output bridge_pkg::sel_t      PSEL_o,
  output bridge_pkg::apb_data_t PWDATA_o,
  input  bridge_pkg::apb_data_t [bridge_pkg::APB_NUM_SLAVES-1:0] PRDATA_i,
  input  bridge_pkg::sel_t      PREADY_i,

  // AXI write response
  output logic                  BVALID_o,
  output bridge_pkg::id_t       BID_o,
  output bridge_pkg::resp_t     BRESP_o,
  input  logic                  BREADY_i,

  // AXI read response
  output logic                  RVALID_o,
  output bridge_pkg::id_t       RID_o,
  output bridge_pkg::axi_data_t RDATA_o,
  output bridge_pkg::resp_t     RRESP_o,
  output logic                  RLAST_o,
  input  logic                  RREADY_i
);

  import bridge_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_BEAT1,
    ST_BEAT2,
    ST_WR_RESP,
    ST_RD_RESP
  } state_t;

  state_t                  state;
  state_t                  state_nxt;

  // Request being served
  logic                    cur_write;
  id_t                     cur_id;
  addr_t                   cur_addr;
  logic                    cur_is64;
  apb_data_t [1:0]         cur_wdata;
  apb_data_t [1:0]         rdata_q;    // Read words packed for RDATA

  addr_t                   beat_addr;
  logic [SLAVE_SEL_W-1:0]  slv_idx;
  logic                    beat_active;
  logic                    beat_done;

  // ----------------------------------------------------------------------
  // Request selection, reads first
  // ----------------------------------------------------------------------
  assign rd_pop_o = (state == ST_IDLE) & rd_pending_i;
  assign wr_pop_o = (state == ST_IDLE) & ~rd_pending_i & wr_pending_i;

  // ----------------------------------------------------------------------
  // APB beat
  // ----------------------------------------------------------------------
  assign beat_active = (state == ST_BEAT1) | (state == ST_BEAT2);

  // Second beat of a 64-bit transfer targets the upper word
  assign beat_addr = (state == ST_BEAT2) ? cur_addr + addr_t'(4) : cur_addr;
  assign slv_idx   = beat_addr[APB_ADDR_W +: SLAVE_SEL_W];
  assign beat_done = beat_active & PREADY_i[slv_idx];

  assign PENABLE_o = beat_active;   // Held with PSEL until PREADY
  assign PWRITE_o  = cur_write;
  assign PADDR_o   = beat_addr[APB_ADDR_W-1:0];
  assign PWDATA_o  = cur_wdata[beat_addr[2]];   // Bit 2 picks the word

  always_comb
  begin
    PSEL_o = '0;
    if (beat_active)
      PSEL_o[slv_idx] = 1'b1;
  end

  // ----------------------------------------------------------------------
  // Responses
  // ----------------------------------------------------------------------
  assign BVALID_o = (state == ST_WR_RESP);
  assign BID_o    = cur_id;
  assign BRESP_o  = RESP_OKAY;

  assign RVALID_o = (state == ST_RD_RESP);
  assign RID_o    = cur_id;
  assign RDATA_o  = rdata_q;
  assign RRESP_o  = RESP_OKAY;
  assign RLAST_o  = 1'b1;   // Single beat reads only

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
      begin
        if (rd_pop_o || wr_pop_o)
          state_nxt = ST_BEAT1;
      end
      ST_BEAT1:
      begin
        if (beat_done)
        begin
          if (cur_is64)
            state_nxt = ST_BEAT2;
          else
            state_nxt = cur_write ? ST_WR_RESP : ST_RD_RESP;
        end
      end
      ST_BEAT2:
      begin
        if (beat_done)
          state_nxt = cur_write ? ST_WR_RESP : ST_RD_RESP;
      end
      ST_WR_RESP:
      begin
        if (BREADY_i)
          state_nxt = ST_IDLE;
      end
      ST_RD_RESP:
      begin
        if (RREADY_i)
          state_nxt = ST_IDLE;
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge ACLK, negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      state     <= ST_IDLE;
      cur_write <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (rd_pop_o)
        cur_write <= 1'b0;
      else if (wr_pop_o)
        cur_write <= 1'b1;
    end
  end

  // Latched request and read data
  always_ff @(posedge ACLK)
  begin
    if (rd_pop_o)
    begin
      cur_id   <= rd_req_i.id;
      cur_addr <= rd_req_i.addr;
      cur_is64 <= rd_req_i.is64;
      rdata_q  <= '0;   // Unused half of a 32-bit read returns zero
    end
    else if (wr_pop_o)
    begin
      cur_id    <= wr_req_i.id;
      cur_addr  <= wr_req_i.addr;
      cur_is64  <= wr_req_i.is64;
      cur_wdata <= wr_req_i.data;
    end

    if (beat_done && !cur_write)
      rdata_q[beat_addr[2]] <= PRDATA_i[slv_idx];
  end

endmodule

//--- hdl/axi_apb_bridge.sv
// AXI4 to APB bridge top level

`timescale 1ns/1ns

module axi_apb_bridge
(
  input  logic                  ACLK,
  input  logic                  ARESETn,

  // ----------------------------------------------------------------------
  // AXI target port
  // ----------------------------------------------------------------------
  input  logic                  AWVALID_i,
  input  bridge_pkg::id_t       AWID_i,
  input  bridge_pkg::addr_t     AWADDR_i,
  input  logic [2:0]            AWSIZE_i,
  output logic                  AWREADY_o,

  input  logic                  WVALID_i,
  input  bridge_pkg::axi_data_t WDATA_i,
  output logic                  WREADY_o,

  output logic                  BVALID_o,
  output bridge_pkg::id_t       BID_o,
  output bridge_pkg::resp_t     BRESP_o,
  input  logic                  BREADY_i,

  input  logic                  ARVALID_i,
  input  bridge_pkg::id_t       ARID_i,
  input  bridge_pkg::addr_t     ARADDR_i,
  input  logic [2:0]            ARSIZE_i,
  output logic                  ARREADY_o,

  output logic                  RVALID_o,
  output bridge_pkg::id_t       RID_o,
  output bridge_pkg::axi_data_t RDATA_o,
  output bridge_pkg::resp_t     RRESP_o,
  output logic                  RLAST_o,
  input  logic                  RREADY_i,

  // ----------------------------------------------------------------------
  // APB master port
  // ----------------------------------------------------------------------
  output logic                  PENABLE_o,
  output logic                  PWRITE_o,
  output bridge_pkg::apb_addr_t PADDR_o,
  output bridge_pkg::sel_t      PSEL_o,
  output bridge_pkg::apb_data_t PWDATA_o,
  input  bridge_pkg::apb_data_t [bridge_pkg::APB_NUM_SLAVES-1:0] PRDATA_i,
  input  bridge_pkg::sel_t      PREADY_i
);

  import bridge_pkg::*;

  // Capture to queues
  logic    wr_push;
  logic    rd_push;
  logic    wr_full;
  logic    rd_full;
  wr_req_t wr_req_in;
  rd_req_t rd_req_in;

  // Queues to sequencer
  logic    wr_pending;
  logic    rd_pending;
  logic    wr_pop;
  logic    rd_pop;
  wr_req_t wr_head;
  rd_req_t rd_head;

  axi_req_capture u_capture
  (
    .ACLK      ( ACLK      ),
    .ARESETn   ( ARESETn   ),
    .AWVALID_i ( AWVALID_i ),
    .AWID_i    ( AWID_i    ),
    .AWADDR_i  ( AWADDR_i  ),
    .AWSIZE_i  ( AWSIZE_i  ),
    .AWREADY_o ( AWREADY_o ),
    .WVALID_i  ( WVALID_i  ),
    .WDATA_i   ( WDATA_i   ),
    .WREADY_o  ( WREADY_o  ),
    .ARVALID_i ( ARVALID_i ),
    .ARID_i    ( ARID_i    ),
    .ARADDR_i  ( ARADDR_i  ),
    .ARSIZE_i  ( ARSIZE_i  ),
    .ARREADY_o ( ARREADY_o ),
    .wr_full_i ( wr_full   ),
    .rd_full_i ( rd_full   ),
    .wr_push_o ( wr_push   ),
    .rd_push_o ( rd_push   ),
    .wr_req_o  ( wr_req_in ),
    .rd_req_o  ( rd_req_in )
  );

  req_fifo #(.payload_t(wr_req_t)) u_wr_fifo
  (
    .ACLK        ( ACLK       ),
    .ARESETn     ( ARESETn    ),
    .push_i      ( wr_push    ),
    .data_i      ( wr_req_in  ),
    .full_o      ( wr_full    ),
    .pop_i       ( wr_pop     ),
    .data_o      ( wr_head    ),
    .not_empty_o ( wr_pending )
  );

  req_fifo #(.payload_t(rd_req_t)) u_rd_fifo
  (
    .ACLK        ( ACLK       ),
    .ARESETn     ( ARESETn    ),
    .push_i      ( rd_push    ),
    .data_i      ( rd_req_in  ),
    .full_o      ( rd_full    ),
    .pop_i       ( rd_pop     ),
    .data_o      ( rd_head    ),
    .not_empty_o ( rd_pending )
  );

  apb_sequencer u_sequencer
  (
    .ACLK         ( ACLK       ),
    .ARESETn      ( ARESETn    ),
    .wr_req_i     ( wr_head    ),
    .wr_pending_i ( wr_pending ),
    .wr_pop_o     ( wr_pop     ),
    .rd_req_i     ( rd_head    ),
    .rd_pending_i ( rd_pending ),
    .rd_pop_o     ( rd_pop     ),
    .PENABLE_o    ( PENABLE_o  ),
    .PWRITE_o     ( PWRITE_o   ),
    .PADDR_o      ( PADDR_o    ),
    .PSEL_o       ( PSEL_o     ),
    .PWDATA_o     ( PWDATA_o   ),
    .PRDATA_i     ( PRDATA_i   ),
    .PREADY_i     ( PREADY_i   ),
    .BVALID_o     ( BVALID_o   ),
    .BID_o        ( BID_o      ),
    .BRESP_o      ( BRESP_o    ),
    .BREADY_i     ( BREADY_i   ),
    .RVALID_o     ( RVALID_o   ),
    .RID_o        ( RID_o      ),
    .RDATA_o      ( RDATA_o    ),
    .RRESP_o      ( RRESP_o    ),
    .RLAST_o      ( RLAST_o    ),
    .RREADY_i     ( RREADY_i   )
  );

endmodule

//--- bench/bridge_props.sv
// Bridge protocol assertions

`timescale 1ns/1ns

module bridge_props
(
  input logic                  ACLK,
  input logic                  ARESETn,
  input logic                  PENABLE_o,
  input bridge_pkg::sel_t      PSEL_o,
  input logic                  BVALID_o,
  input logic                  BREADY_i,
  input bridge_pkg::id_t       BID_o,
  input bridge_pkg::resp_t     BRESP_o,
  input logic                  RVALID_o,
  input logic                  RREADY_i,
  input bridge_pkg::id_t       RID_o,
  input bridge_pkg::axi_data_t RDATA_o,
  input bridge_pkg::resp_t     RRESP_o,
  input logic                  RLAST_o
);

  // One slave per APB access
  a_psel_onehot: assert property (@(posedge ACLK) disable iff (!ARESETn)
    PENABLE_o |-> $onehot(PSEL_o))
    else $error("PSEL_o is not one-hot during an APB access");

  a_b_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    BVALID_o && !BREADY_i |=> BVALID_o && $stable(BID_o) && $stable(BRESP_o))
    else $error("B channel changed before BREADY_i");

  a_r_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    RVALID_o && !RREADY_i |=> RVALID_o && $stable(RID_o) && $stable(RDATA_o)
      && $stable(RRESP_o) && $stable(RLAST_o))
    else $error("R channel changed before RREADY_i");

  a_reset_idle: assert property (@(posedge ACLK)
    !ARESETn |-> !PENABLE_o && !BVALID_o && !RVALID_o)
    else $error("Bus activity during reset");

endmodule

bind axi_apb_bridge bridge_props u_props
(
  .ACLK      ( ACLK      ),
  .ARESETn   ( ARESETn   ),
  .PENABLE_o ( PENABLE_o ),
  .PSEL_o    ( PSEL_o    ),
  .BVALID_o  ( BVALID_o  ),
  .BREADY_i  ( BREADY_i  ),
  .BID_o     ( BID_o     ),
  .BRESP_o   ( BRESP_o   ),
  .RVALID_o  ( RVALID_o  ),
  .RREADY_i  ( RREADY_i  ),
  .RID_o     ( RID_o     ),
  .RDATA_o   ( RDATA_o   ),
  .RRESP_o   ( RRESP_o   ),
  .RLAST_o   ( RLAST_o   )
);

//--- bench/tb_axi_apb_bridge.sv
// AXI to APB bridge testbench

`timescale 1ns/1ns

module tb_axi_apb_bridge;

  import bridge_pkg::*;

  // About 140 transactions of up to 15 cycles each, with wide margin
  localparam int CYCLE_LIMIT = 4000;
  localparam int SLV_WORDS   = 2**(APB_ADDR_W-2);

  logic       ACLK = 1'b0;
  logic       ARESETn;
  logic       AWVALID_i;
  id_t        AWID_i;
  addr_t      AWADDR_i;
  logic [2:0] AWSIZE_i;
  logic       AWREADY_o;
  logic       WVALID_i;
  axi_data_t  WDATA_i;
  logic       WREADY_o;
  logic       BVALID_o;
  id_t        BID_o;
  resp_t      BRESP_o;
  logic       BREADY_i;
  logic       ARVALID_i;
  id_t        ARID_i;
  addr_t      ARADDR_i;
  logic [2:0] ARSIZE_i;
  logic       ARREADY_o;
  logic       RVALID_o;
  id_t        RID_o;
  axi_data_t  RDATA_o;
  resp_t      RRESP_o;
  logic       RLAST_o;
  logic       RREADY_i;
  logic       PENABLE_o;
  logic       PWRITE_o;
  apb_addr_t  PADDR_o;
  sel_t       PSEL_o;
  apb_data_t  PWDATA_o;
  apb_data_t [APB_NUM_SLAVES-1:0] PRDATA_i;
  sel_t       PREADY_i = '1;

  apb_data_t  slv_mem [APB_NUM_SLAVES][SLV_WORDS];   // Word memories of the slaves
  logic       stall_en = 1'b0;
  int         cycle_cnt = 0;

  // Responses in arrival order
  id_t        b_id_q [$];
  resp_t      b_resp_q [$];
  id_t        r_id_q [$];
  axi_data_t  r_data_q [$];
  resp_t      r_resp_q [$];
  logic       r_last_q [$];

  axi_apb_bridge axi_apb_bridge_inst (.*);

  always #10 ACLK = ~ACLK;

  // ----------------------------------------------------------------------
  // APB slave models
  // ----------------------------------------------------------------------
  function automatic apb_data_t fill_word(input int slv, input int word);
    return {8'h5A, 8'(slv), 16'(word)};   // Unique per slave and word
  endfunction

  for (genvar g = 0; g < APB_NUM_SLAVES; g++)
  begin : g_slave
    assign PRDATA_i[g] = slv_mem[g][PADDR_o[APB_ADDR_W-1:2]];
  end

  always @(posedge ACLK)
  begin
    if (!ARESETn)
    begin
      for (int s = 0; s < APB_NUM_SLAVES; s++)
        for (int w = 0; w < SLV_WORDS; w++)
          slv_mem[s][w] <= fill_word(s, w);
      PREADY_i <= '1;
    end
    else
    begin
      for (int s = 0; s < APB_NUM_SLAVES; s++)
        if (PSEL_o[s] && PENABLE_o && PWRITE_o && PREADY_i[s])
          slv_mem[s][PADDR_o[APB_ADDR_W-1:2]] <= PWDATA_o;
      PREADY_i <= stall_en ? sel_t'($urandom) : '1;   // Random wait states
    end
  end

  // B and R handshakes
  always @(posedge ACLK)
  begin
    if (ARESETn && BVALID_o && BREADY_i)
    begin
      b_id_q.push_back(BID_o);
      b_resp_q.push_back(BRESP_o);
    end
    if (ARESETn && RVALID_o && RREADY_i)
    begin
      r_id_q.push_back(RID_o);
      r_data_q.push_back(RDATA_o);
      r_resp_q.push_back(RRESP_o);
      r_last_q.push_back(RLAST_o);
    end
  end

  always @(posedge ACLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("Timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
      fail_stop();
    end
  end

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic fail_stop();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input axi_data_t exp_v, input axi_data_t act_v);
    if (act_v !== exp_v)
    begin
      $display("Mismatch in %s: expected %h, actual %h", name, exp_v, act_v);
      fail_stop();
    end
  endtask

  task automatic check_id(input string name, input id_t exp_v, input id_t act_v);
    if (act_v !== exp_v)
    begin
      $display("Mismatch in %s: expected ID %h, actual ID %h", name, exp_v, act_v);
      fail_stop();
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp_v, input resp_t act_v);
    if (act_v !== exp_v)
    begin
      $display("Mismatch in %s: expected response %b, actual %b", name, exp_v, act_v);
      fail_stop();
    end
  endtask

  // ----------------------------------------------------------------------
  // AXI driver tasks
  // ----------------------------------------------------------------------
  task automatic start_write(input id_t id, input addr_t addr, input logic [2:0] size,
                             input axi_data_t data);
    @(posedge ACLK);
    AWVALID_i <= 1'b1;
    WVALID_i  <= 1'b1;
    AWID_i    <= id;
    AWADDR_i  <= addr;
    AWSIZE_i  <= size;
    WDATA_i   <= data;
  endtask

  task automatic accept_write();
    @(negedge ACLK);
    while (!(AWREADY_o && WREADY_o))
      @(negedge ACLK);
    @(posedge ACLK);   // Handshake edge
    AWVALID_i <= 1'b0;
    WVALID_i  <= 1'b0;
  endtask

  task automatic send_write(input id_t id, input addr_t addr, input logic [2:0] size,
                            input axi_data_t data);
    start_write(id, addr, size, data);
    accept_write();
  endtask

  task automatic send_read(input id_t id, input addr_t addr, input logic [2:0] size);
    @(posedge ACLK);
    ARVALID_i <= 1'b1;
    ARID_i    <= id;
    ARADDR_i  <= addr;
    ARSIZE_i  <= size;
    @(negedge ACLK);
    while (!ARREADY_o)
      @(negedge ACLK);
    @(posedge ACLK);
    ARVALID_i <= 1'b0;
  endtask

  task automatic expect_b(input string name, input id_t exp_id);
    while (b_id_q.size() == 0)
      @(negedge ACLK);
    check_id(name, exp_id, b_id_q.pop_front());
    check_resp(name, 2'b00, b_resp_q.pop_front());   // AXI OKAY
  endtask

  task automatic expect_r(input string name, input id_t exp_id, input axi_data_t exp_data);
    while (r_id_q.size() == 0)
      @(negedge ACLK);
    check_id(name, exp_id, r_id_q.pop_front());
    check_data(name, exp_data, r_data_q.pop_front());
    check_resp(name, 2'b00, r_resp_q.pop_front());
    if (!r_last_q.pop_front())
    begin
      $display("RLAST_o was low on a read response in %s", name);
      fail_stop();
    end
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic narrow_rw();
    // Slave 1, words 0x10 and 0x11, junk in the unused lane
    send_write(4'h1, 32'h0000_1040, 3'd2, {32'hDEAD_BEEF, 32'h1234_5678});
    expect_b("narrow_rw", 4'h1);
    send_write(4'h2, 32'h0000_1044, 3'd2, {32'h9ABC_DEF0, 32'hDEAD_BEEF});
    expect_b("narrow_rw", 4'h2);
    check_data("narrow_rw", 64'h9ABC_DEF0_1234_5678, {slv_mem[1][17], slv_mem[1][16]});
    send_read(4'h3, 32'h0000_1040, 3'd2);
    expect_r("narrow_rw", 4'h3, 64'h0000_0000_1234_5678);
    send_read(4'h4, 32'h0000_1044, 3'd2);
    expect_r("narrow_rw", 4'h4, 64'h9ABC_DEF0_0000_0000);
  endtask

  task automatic wide_rw();
    send_write(4'h5, 32'h0000_2080, 3'd3, 64'hCAFE_F00D_0BAD_1DEA);
    expect_b("wide_rw", 4'h5);
    check_data("wide_rw", 64'hCAFE_F00D_0BAD_1DEA, {slv_mem[2][33], slv_mem[2][32]});
    send_read(4'h6, 32'h0000_2080, 3'd3);
    expect_r("wide_rw", 4'h6, 64'hCAFE_F00D_0BAD_1DEA);
    send_read(4'h7, 32'h0000_1040, 3'd3);   // Words left by narrow_rw
    expect_r("wide_rw", 4'h7, 64'h9ABC_DEF0_1234_5678);
  endtask

  task automatic slave_decode();
    apb_data_t exp_w;
    for (int s = 0; s < APB_NUM_SLAVES; s++)
    begin
      send_write(id_t'(s), {17'd0, 3'(s), 12'h200}, 3'd2, {32'h0, 32'hD0C0_0000 | s});
      expect_b("slave_decode", id_t'(s));
      for (int t = 0; t < APB_NUM_SLAVES; t++)
      begin
        exp_w = (t <= s) ? apb_data_t'(32'hD0C0_0000 | t) : fill_word(t, 128);
        check_data("slave_decode", axi_data_t'(exp_w), axi_data_t'(slv_mem[t][128]));
      end
    end
    for (int s = 0; s < APB_NUM_SLAVES; s++)
    begin
      send_read(id_t'(s), {17'd0, 3'(s), 12'h200}, 3'd2);
      expect_r("slave_decode", id_t'(s), {32'h0, 32'hD0C0_0000 | s});
    end
  endtask

  task automatic random_wait_states();
    addr_t     addr;
    axi_data_t data;
    apb_data_t word;
    @(posedge ACLK);
    stall_en <= 1'b1;
    for (int i = 0; i < 24; i++)
    begin
      // Lower half of each window, clear of read_id_echo
      addr = {17'd0, 3'($urandom % 8), 1'b0, 8'($urandom % 256), 3'b000};
      data = {$urandom, $urandom};
      word = $urandom;
      send_write(id_t'(4 * i), addr, 3'd3, data);
      expect_b("random_wait_states", id_t'(4 * i));
      send_read(id_t'(4 * i + 1), addr, 3'd3);
      expect_r("random_wait_states", id_t'(4 * i + 1), data);
      send_write(id_t'(4 * i + 2), addr + 4, 3'd2, {word, 32'h0});
      expect_b("random_wait_states", id_t'(4 * i + 2));
      send_read(id_t'(4 * i + 3), addr, 3'd3);
      expect_r("random_wait_states", id_t'(4 * i + 3), {word, data[31:0]});
    end
    @(posedge ACLK);
    stall_en <= 1'b0;
  endtask

  task automatic write_backpressure();
    @(posedge ACLK);
    BREADY_i <= 1'b0;
    for (int i = 0; i < 5; i++)
      send_write(id_t'(i + 8), 32'h0000_3300 + 4 * i, 3'd2, {2{32'hB0B0_0000 | i}});
    // One write stalls in the sequencer, four fill the queue
    start_write(id_t'(13), 32'h0000_3314, 3'd2, {2{32'hB0B0_0005}});
    repeat (12)
    begin
      @(negedge ACLK);
      if (AWREADY_o)
      begin
        $display("AWREADY_o was high while the write queue was full");
        fail_stop();
      end
    end
    @(posedge ACLK);
    BREADY_i <= 1'b1;
    accept_write();
    for (int i = 0; i < 6; i++)
    begin
      expect_b("write_backpressure", id_t'(i + 8));
      check_data("write_backpressure", axi_data_t'(32'hB0B0_0000 | i),
                 axi_data_t'(slv_mem[3][192 + i]));
    end
  endtask

  task automatic read_id_echo();
    id_t ids [4];
    ids = '{4'h9, 4'h3, 4'hE, 4'h6};
    for (int i = 0; i < 4; i++)
      send_read(ids[i], 32'h0000_5F00 + 8 * i, 3'd3);   // Slave 5, word 0x3C0 on
    for (int i = 0; i < 4; i++)
      expect_r("read_id_echo", ids[i], {fill_word(5, 961 + 2 * i), fill_word(5, 960 + 2 * i)});
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial
  begin
    void'($urandom(52));
    ARESETn   <= 1'b0;
    AWVALID_i <= 1'b0;
    AWID_i    <= '0;
    AWADDR_i  <= '0;
    AWSIZE_i  <= '0;
    WVALID_i  <= 1'b0;
    WDATA_i   <= '0;
    BREADY_i  <= 1'b1;
    ARVALID_i <= 1'b0;
    ARID_i    <= '0;
    ARADDR_i  <= '0;
    ARSIZE_i  <= '0;
    RREADY_i  <= 1'b1;
    repeat (3) @(posedge ACLK);
    ARESETn <= 1'b1;
    @(posedge ACLK);
    narrow_rw();
    wide_rw();
    slave_decode();
    random_wait_states();
    write_backpressure();
    read_id_echo();
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- sources.f
hdl/bridge_pkg.sv
hdl/axi_req_capture.sv
hdl/req_fifo.sv
hdl/apb_sequencer.sv
hdl/axi_apb_bridge.sv
bench/bridge_props.sv
bench/tb_axi_apb_bridge.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_apb_bridge -f sources.f

./obj_dir/Vtb_axi_apb_bridge | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

if ! grep -q "TEST PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation finished cleanly"
